//--- files.f
verilog/pr_queue_pkg.sv
verilog/pr_request_fifo.sv
verilog/pr_issue_wb.sv
verilog/pr_axi_read_port.sv
verilog/pr_queue_unit.sv
sim/pr_queue_clk_gen.sv
sim/pr_queue_tb.sv

//--- sim/pr_queue_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pr_queue_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Active low reset, released on a clock edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/pr_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pr_queue_tb;

    localparam int DEPTH        = 4;
    localparam int WAIT_LIMIT   = 50;
    localparam int EMPTY_WINDOW = 20;
    localparam int NUM_ROWS     = 28;

    typedef enum logic [2:0] {
        ISSUE,
        ACK,
        PEEK,
        POP,
        EMPTY_POP
    } row_kind_e;

    // One table row with the issue_ready level expected once the row is done
    typedef struct packed {
        row_kind_e  kind;
        logic [7:0] ou_id;
        logic [7:0] grid_slot;
        logic [2:0] id;
        logic       exp_ready;
    } row_t;

    logic                    clk;
    logic                    rst;
    pr_queue_pkg::pr_issue_t issue;
    logic                    issue_ready;
    pr_queue_pkg::pr_wb_t    wb;
    logic                    wb_ack;
    logic                    pr_request_pending;
    logic [3:0]              s_axi_araddr;
    logic                    s_axi_arvalid;
    logic                    s_axi_arready;
    logic [31:0]             s_axi_rdata;
    logic                    s_axi_rvalid;
    logic                    s_axi_rready;

    row_t                      rows [NUM_ROWS];
    pr_queue_pkg::pr_request_t model_q [$];
    int                        check_errors = 0;
    int                        timeouts = 0;

    pr_queue_clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    pr_queue_unit #(
        .DEPTH (DEPTH)
    ) dut_i (
        .clk                (clk),
        .rst                (rst),
        .issue              (issue),
        .issue_ready        (issue_ready),
        .wb                 (wb),
        .wb_ack             (wb_ack),
        .pr_request_pending (pr_request_pending),
        .s_axi_araddr       (s_axi_araddr),
        .s_axi_arvalid      (s_axi_arvalid),
        .s_axi_arready      (s_axi_arready),
        .s_axi_rdata        (s_axi_rdata),
        .s_axi_rvalid       (s_axi_rvalid),
        .s_axi_rready       (s_axi_rready)
    );

    // Sample and drive 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)",
                     $time, msg, actual, expected);
            check_errors++;
        end
    endtask

    task automatic issue_request(input row_t r);
        int cycles;
        cycles = 0;
        while (!issue_ready && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!issue_ready) begin
            $display("Timeout at %0t: issue_ready never rose for id %0d", $time, r.id);
            timeouts++;
            return;
        end
        check(wb.done, 1'b0, "wb.done high before issue");
        issue.new_request       = 1'b1;
        issue.id                = r.id;
        issue.request.ou_id     = r.ou_id;
        issue.request.grid_slot = r.grid_slot;
        next_cycle();
        issue.new_request = 1'b0;
        model_q.push_back({r.ou_id, r.grid_slot});
        check(wb.done, 1'b1, "wb.done one cycle after issue");
        check(wb.id, r.id, "wb.id after issue");
        check(issue_ready, 1'b0, "issue_ready after issue");
        check(pr_request_pending, 1'b1, "pending after issue");
    endtask

    task automatic ack_request();
        repeat (2) begin
            check(wb.done, 1'b1, "wb.done held while waiting for ack");
            check(issue_ready, 1'b0, "issue_ready while waiting for ack");
            next_cycle();
        end
        wb_ack = 1'b1;
        check(wb.done, 1'b1, "wb.done in ack cycle");
        check(issue_ready, 1'b0, "issue_ready in ack cycle");
        next_cycle();
        wb_ack = 1'b0;
        check(wb.done, 1'b0, "wb.done after ack");
        check(issue_ready, model_q.size() < DEPTH, "issue_ready after ack");
    endtask

    // Finish a read whose address phase is already driven and check the data
    task automatic complete_read(input logic is_pop);
        int          cycles;
        int          delay;
        logic [31:0] exp_data;
        cycles = 0;
        while (!s_axi_arready && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        s_axi_arvalid = 1'b0;
        if (!s_axi_arready) begin
            $display("Timeout at %0t: arready never rose for a read", $time);
            timeouts++;
            return;
        end
        check(cycles, 1, "arready latency after arvalid");
        exp_data = (model_q.size() != 0) ? {16'h0000, model_q[0]} : 32'h0;
        cycles = 0;
        while (!s_axi_rvalid && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!s_axi_rvalid) begin
            $display("Timeout at %0t: rvalid never rose after arready", $time);
            timeouts++;
            return;
        end
        check(cycles, 1, "rvalid latency after arready");
        check(s_axi_arready, 1'b0, "arready is a single-cycle pulse");
        check(s_axi_rdata, exp_data, "read data");
        // Back-pressure before taking the data
        delay = $urandom % 6;
        repeat (delay) begin
            next_cycle();
            check(s_axi_rvalid, 1'b1, "rvalid held under back-pressure");
            check(s_axi_rdata, exp_data, "rdata held under back-pressure");
        end
        s_axi_rready = 1'b1;
        next_cycle();
        s_axi_rready = 1'b0;
        check(s_axi_rvalid, 1'b0, "rvalid after handshake");
        if (is_pop) begin
            void'(model_q.pop_front());
        end
        check(pr_request_pending, model_q.size() != 0, "pending after read");
    endtask

    task automatic read_request(input logic [3:0] addr, input logic is_pop);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        complete_read(is_pop);
    endtask

    // Pop held against an empty queue until a request arrives
    task automatic empty_read(input row_t r);
        check(pr_request_pending, 1'b0, "queue empty before blocked read");
        s_axi_araddr  = pr_queue_pkg::POP_ADDR;
        s_axi_arvalid = 1'b1;
        for (int i = 0; i < EMPTY_WINDOW; i++) begin
            next_cycle();
            check(s_axi_arready, 1'b0, "arready on empty queue");
        end
        issue_request(r);
        complete_read(1'b1);
    endtask

    initial begin
        int cycles;
        void'($urandom(32'hed8e));
        issue         = '0;
        wb_ack        = 1'b0;
        s_axi_araddr  = 4'h0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;

        // Completion handshake followed by in-order pops
        rows[0]  = '{ISSUE, 8'hA1, 8'h10, 3'd1, 1'b0};
        rows[1]  = '{ACK,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[2]  = '{POP,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[3]  = '{ISSUE, 8'h22, 8'h31, 3'd2, 1'b0};
        rows[4]  = '{ACK,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[5]  = '{ISSUE, 8'h33, 8'h42, 3'd3, 1'b0};
        rows[6]  = '{ACK,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[7]  = '{ISSUE, 8'h44, 8'h53, 3'd4, 1'b0};
        rows[8]  = '{ACK,   8'h00, 8'h00, 3'd0, 1'b1};
        // Peeks leave the head in place
        rows[9]  = '{PEEK,  8'h00, 8'h00, 3'd0, 1'b1};
        rows[10] = '{PEEK,  8'h00, 8'h00, 3'd0, 1'b1};
        rows[11] = '{POP,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[12] = '{POP,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[13] = '{POP,   8'h00, 8'h00, 3'd0, 1'b1};
        // Fill to DEPTH so ready stays low until a pop
        rows[14] = '{ISSUE, 8'h55, 8'h60, 3'd5, 1'b0};
        rows[15] = '{ACK,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[16] = '{ISSUE, 8'h66, 8'h61, 3'd6, 1'b0};
        rows[17] = '{ACK,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[18] = '{ISSUE, 8'h77, 8'h62, 3'd7, 1'b0};
        rows[19] = '{ACK,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[20] = '{ISSUE, 8'h88, 8'h63, 3'd0, 1'b0};
        rows[21] = '{ACK,   8'h00, 8'h00, 3'd0, 1'b0};
        rows[22] = '{POP,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[23] = '{POP,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[24] = '{POP,   8'h00, 8'h00, 3'd0, 1'b1};
        rows[25] = '{POP,   8'h00, 8'h00, 3'd0, 1'b1};
        // Blocked read released by a later issue
        rows[26] = '{EMPTY_POP, 8'h99, 8'h7F, 3'd2, 1'b0};
        rows[27] = '{ACK,   8'h00, 8'h00, 3'd0, 1'b1};

        cycles = 0;
        while (!rst && cycles < 20) begin
            next_cycle();
            cycles++;
        end
        if (!rst) begin
            $display("Timeout at %0t: reset was never released", $time);
            timeouts++;
        end
        check(issue_ready, 1'b1, "issue_ready after reset");
        check(wb.done, 1'b0, "wb.done after reset");
        check(s_axi_arready, 1'b0, "arready after reset");
        check(s_axi_rvalid, 1'b0, "rvalid after reset");
        check(pr_request_pending, 1'b0, "pending after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            case (rows[i].kind)
                ISSUE:     issue_request(rows[i]);
                ACK:       ack_request();
                PEEK:      read_request(pr_queue_pkg::PEEK_ADDR, 1'b0);
                POP:       read_request(pr_queue_pkg::POP_ADDR, 1'b1);
                EMPTY_POP: empty_read(rows[i]);
                default:   ;
            endcase
            check(issue_ready, rows[i].exp_ready, $sformatf("issue_ready after row %0d", i));
        end

        $display("Errors: %0d check failures, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/pr_axi_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module pr_axi_read_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [3:0]                s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output logic [31:0]               s_axi_rdata,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,
    input  pr_queue_pkg::pr_request_t head,
    input  logic                      head_valid,
    output logic                      pop
);

    // Zero padding above the request in the read word
    localparam int PAD_W = 32 - $bits(pr_queue_pkg::pr_request_t);

    pr_queue_pkg::pr_read_state_e state;
    pr_queue_pkg::pr_read_op_e    addr_op;
    pr_queue_pkg::pr_read_op_e    op;

    logic accept;

    // Address decode, unknown offsets behave as a peek
    always_comb begin
        case (s_axi_araddr)
            pr_queue_pkg::PEEK_ADDR: addr_op = pr_queue_pkg::PR_PEEK;
            pr_queue_pkg::POP_ADDR:  addr_op = pr_queue_pkg::PR_POP;
            default:                 addr_op = pr_queue_pkg::PR_PEEK;
        endcase
    end

    // An address is only taken while something is queued
    assign accept = (state == pr_queue_pkg::RD_ADDR) && s_axi_arvalid && head_valid;

    // Read FSM with registered handshake flags
    always_ff @(posedge clk) begin
        if (!rst) begin
            state         <= pr_queue_pkg::RD_ADDR;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            pop           <= 1'b0;
        end else begin
            // arready and pop are single-cycle pulses
            s_axi_arready <= 1'b0;
            pop           <= 1'b0;

            case (state)
                pr_queue_pkg::RD_ADDR: begin
                    if (accept) begin
                        state         <= pr_queue_pkg::RD_CAPTURE;
                        s_axi_arready <= 1'b1;
                    end
                end

                pr_queue_pkg::RD_CAPTURE: begin
                    state        <= pr_queue_pkg::RD_DATA;
                    s_axi_rvalid <= 1'b1;
                    pop          <= (op == pr_queue_pkg::PR_POP);
                end

                pr_queue_pkg::RD_DATA: begin
                    // rvalid holds until the master takes the data
                    if (s_axi_rready) begin
                        state        <= pr_queue_pkg::RD_ADDR;
                        s_axi_rvalid <= 1'b0;
                    end
                end

                default: begin
                    state <= pr_queue_pkg::RD_ADDR;
                end
            endcase
        end
    end

    // Latched operation for the current read
    always_ff @(posedge clk) begin
        if (accept) begin
            op <= addr_op;
        end
    end

    // Head is sampled once, so rdata stays stable under back-pressure
    always_ff @(posedge clk) begin
        if (state == pr_queue_pkg::RD_CAPTURE) begin
            s_axi_rdata <= {{PAD_W{1'b0}}, head};
        end
    end

endmodule

`default_nettype wire

//--- verilog/pr_issue_wb.sv
`timescale 1ns/1ps
`default_nettype none

module pr_issue_wb (
    input  logic                      clk,
    input  logic                      rst,
    input  pr_queue_pkg::pr_issue_t   issue,
    output logic                      issue_ready,
    input  logic                      fifo_full,
    output logic                      push,
    output pr_queue_pkg::pr_request_t push_data,
    output pr_queue_pkg::pr_wb_t      wb,
    input  logic                      wb_ack
);

    logic                                  waiting_for_ack;
    logic                                  issue_fire;
    logic                                  done_q;
    logic [pr_queue_pkg::ISSUE_ID_W-1:0]   id_q;

    // One request in flight at a time, and only when there is room
    assign issue_ready = !waiting_for_ack && !fifo_full;
    assign issue_fire  = issue.new_request && issue_ready;

    // Queue the request on the issue edge itself
    assign push      = issue_fire;
    assign push_data = issue.request;

    // Ack-wait flag
    always_ff @(posedge clk) begin
        if (!rst) begin
            waiting_for_ack <= 1'b0;
        end else if (issue_fire) begin
            // set wins over clear
            waiting_for_ack <= 1'b1;
        end else if (wb_ack) begin
            waiting_for_ack <= 1'b0;
        end
    end

    // Done strobe, held across the wait and dropped after the ack
    always_ff @(posedge clk) begin
        if (!rst) begin
            done_q <= 1'b0;
        end else if (!waiting_for_ack) begin
            done_q <= issue_fire;
        end else if (wb_ack) begin
            done_q <= 1'b0;
        end
    end

    // Id follows the issue side until a request is taken
    always_ff @(posedge clk) begin
        if (!waiting_for_ack) begin
            id_q <= issue.id;
        end
    end

    assign wb.done = done_q;
    assign wb.id   = id_q;

endmodule

`default_nettype wire

//--- verilog/pr_queue_pkg.sv
`default_nettype none

package pr_queue_pkg;

    // Field widths of a reconfiguration request
    localparam int OU_ID_W     = 8;
    localparam int GRID_SLOT_W = 8;

    // Width of the instruction id carried from issue to writeback
    localparam int ISSUE_ID_W  = 3;

    // Read offsets on the AXI-lite window
    localparam logic [3:0] PEEK_ADDR = 4'h4;
    localparam logic [3:0] POP_ADDR  = 4'h8;

    // One queued request, packs as {ou_id, grid_slot}
    typedef struct packed {
        logic [OU_ID_W-1:0]     ou_id;
        logic [GRID_SLOT_W-1:0] grid_slot;
    } pr_request_t;

    // Core to unit issue bundle
    typedef struct packed {
        logic                  new_request;
        logic [ISSUE_ID_W-1:0] id;
        pr_request_t           request;
    } pr_issue_t;

    // Completion bundle back to the core
    typedef struct packed {
        logic                  done;
        logic [ISSUE_ID_W-1:0] id;
    } pr_wb_t;

    // Operation decoded from the read address
    typedef enum logic {
        PR_PEEK,
        PR_POP
    } pr_read_op_e;

    // Read port FSM states
    typedef enum logic [1:0] {
        RD_ADDR,
        RD_CAPTURE,
        RD_DATA
    } pr_read_state_e;

endpackage

`default_nettype wire

//--- verilog/pr_queue_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pr_queue_unit #(
    parameter int DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,

    // Issue and writeback toward the core
    input  pr_queue_pkg::pr_issue_t issue,
    output logic                    issue_ready,
    output pr_queue_pkg::pr_wb_t    wb,
    input  logic                    wb_ack,

    // Queue holds at least one request
    output logic                    pr_request_pending,

    // AXI-lite read channel for the management agent
    input  logic [3:0]              s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output logic [31:0]             s_axi_rdata,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready
);

    logic                      fifo_push;
    pr_queue_pkg::pr_request_t fifo_push_data;
    logic                      fifo_pop;
    pr_queue_pkg::pr_request_t fifo_head;
    logic                      fifo_valid;
    logic                      fifo_full;

    assign pr_request_pending = fifo_valid;

    pr_issue_wb issue_wb_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_ready (issue_ready),
        .fifo_full   (fifo_full),
        .push        (fifo_push),
        .push_data   (fifo_push_data),
        .wb          (wb),
        .wb_ack      (wb_ack)
    );

    pr_request_fifo #(
        .DEPTH (DEPTH)
    ) request_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (fifo_push),
        .data_in  (fifo_push_data),
        .pop      (fifo_pop),
        .data_out (fifo_head),
        .valid    (fifo_valid),
        .full     (fifo_full)
    );

    pr_axi_read_port read_port_i (
        .clk           (clk),
        .rst           (rst),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .head          (fifo_head),
        .head_valid    (fifo_valid),
        .pop           (fifo_pop)
    );

endmodule

`default_nettype wire

//--- verilog/pr_request_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pr_request_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  pr_queue_pkg::pr_request_t data_in,
    input  logic                      pop,
    output pr_queue_pkg::pr_request_t data_out,
    output logic                      valid,
    output logic                      full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);

    pr_queue_pkg::pr_request_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // Writes are dropped when full, reads when empty
    assign do_push = push && !full;
    assign do_pop  = pop && valid;

    assign valid    = (count != '0);
    assign full     = (count == FULL_CNT);
    assign data_out = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            if (wr_ptr == LAST_PTR) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            if (rd_ptr == LAST_PTR) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, a simultaneous push and pop leaves it unchanged
    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire
